// ==== source/game_pkg.sv ====
// screen, sprite, terrain, button index, direction and timing constants
package game_pkg;

    // ------------------------------------------------------------------------
    // screen and sprite geometry
    // ------------------------------------------------------------------------
    localparam int h_disp        = 640;     // visible width
    localparam int v_disp        = 480;     // visible height
    localparam int h_disp_half   = 320;     // player stops here, field scrolls
    localparam int user_width    = 16;
    localparam int user_height   = 16;
    localparam int chip_size     = 16;      // terrain column width in pixels
    localparam int chip_shift    = $clog2(chip_size);
    localparam int h_chip_number = 40;      // columns on one screen

    // bit positions in the 6-bit button word
    localparam int btn_right = 0;
    localparam int btn_left  = 1;
    localparam int btn_a     = 4;           // jump key

    // free-direction word, a set bit allows motion that way
    localparam int free_up    = 3;
    localparam int free_down  = 2;
    localparam int free_right = 1;
    localparam int free_left  = 0;

    // ------------------------------------------------------------------------
    // facing and vertical state codes
    // ------------------------------------------------------------------------
    localparam logic [1:0] xdir_idle  = 2'd0;
    localparam logic [1:0] xdir_left  = 2'd1;
    localparam logic [1:0] xdir_right = 2'd2;

    localparam logic [1:0] ydir_idle = 2'd0;   // standing on ground
    localparam logic [1:0] ydir_jump = 2'd1;   // rising
    localparam logic [1:0] ydir_fall = 2'd2;

    // long-press ramp, gaps counted in ticks
    localparam int key_start_time = 14;     // first gap
    localparam int key_end_time   = 1;      // step fires here
    localparam int key_comp_time  = 3;      // shortest gap

    // jump arc
    localparam int jump_height_max   = 50;  // rise per jump in pixels
    localparam int fall_start_height = 30;  // speed index when walking off a ledge
    localparam int jump_max_count    = 2;   // jumps per airtime

    localparam int debounce_samples = 2;    // equal tick samples before btn moves

endpackage

// ==== source/tick_gen.sv ====
// clock divider producing the one-cycle millisecond enable
module tick_gen #(
    parameter int tick_div = 100000         // clocks per tick
) (
    input  logic iClk,
    input  logic arst_n,
    output logic tick_1ms
);

    localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [cnt_w-1:0] cnt;                  // clocks left before next pulse

    // ------------------------------------------------------------------------
    // down-counter, reload at zero
    // ------------------------------------------------------------------------
    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            cnt      <= cnt_w'(tick_div - 1);
            tick_1ms <= 1'b0;
        end else if (cnt == '0) begin
            cnt      <= cnt_w'(tick_div - 1);   // next period
            tick_1ms <= 1'b1;                   // one clock wide
        end else begin
            cnt      <= cnt - 1'b1;
            tick_1ms <= 1'b0;
        end
    end

endmodule

// ==== source/button_sync.sv ====
// push-button synchronizer and tick-sampled debouncer
module button_sync (
    input  logic       iClk,
    input  logic       arst_n,
    input  logic       tick_1ms,
    input  logic [5:0] btn_raw,
    output logic [5:0] btn
);

    import game_pkg::*;

    localparam int run_w = $clog2(debounce_samples + 1);

    logic [5:0]       sync_1;               // first stage, may go metastable
    logic [5:0]       sync_2;               // safe to use
    logic [5:0]       samp_q;               // word seen on the last tick
    logic [run_w-1:0] run_cnt;              // equal samples in a row

    // two flops into the clock domain
    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= btn_raw;
            sync_2 <= sync_1;
        end
    end

    // ------------------------------------------------------------------------
    // debounce, one sample per tick
    // a bouncing contact keeps resetting the run
    // ------------------------------------------------------------------------
    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            samp_q  <= '0;
            run_cnt <= '0;
            btn     <= '0;
        end else if (tick_1ms) begin
            samp_q <= sync_2;
            if (sync_2 != samp_q) begin
                run_cnt <= run_w'(1);           // new level, first sample
            end else if (run_cnt < run_w'(debounce_samples)) begin
                run_cnt <= run_cnt + 1'b1;      // saturates at the limit
            end
            if (sync_2 == samp_q && run_cnt >= run_w'(debounce_samples - 1)) begin
                btn <= sync_2;                  // stable long enough
            end
        end
    end

endmodule

// ==== source/terrain_probe.sv ====
// ground-height lookup and free-direction bits for the player box
module terrain_probe (
    input  logic        iClk,
    input  logic        arst_n,
    input  logic [9:0]  user_xs,
    input  logic [9:0]  user_xe,
    input  logic [9:0]  user_ye,
    input  logic [15:0] field_x,
    input  logic [15:0] map_width,
    output logic [3:0]  map_free
);

    import game_pkg::*;

    // ------------------------------------------------------------------------
    // ground top y per world column, pattern repeats every 64 columns
    // ------------------------------------------------------------------------
    function automatic logic [9:0] ground_top(input logic [5:0] col);
        logic [9:0] top;
        case (col) inside
            [6'd48:6'd51]: top = 10'd368;   // raised block, needs a jump
            [6'd52:6'd55]: top = 10'd384;   // step down
            [6'd60:6'd63]: top = 10'd416;   // dip before the wrap
            default:       top = 10'd400;   // plain floor
        endcase
        return top;
    endfunction

    logic [15:0] px_lfoot;                  // world x under left edge
    logic [15:0] px_rfoot;                  // world x under right edge
    logic [15:0] px_ahead;                  // first pixel right of the box
    logic [15:0] px_behind;                 // first pixel left of the box
    logic [15:0] col_ahead;
    logic [9:0]  top_lfoot;
    logic [9:0]  top_rfoot;
    logic [9:0]  top_ahead;
    logic [9:0]  top_behind;
    logic        fall_ok;
    logic        blocked_right;
    logic        blocked_left;

    always_comb begin
        px_lfoot   = field_x + {6'd0, user_xs};
        px_rfoot   = field_x + {6'd0, user_xe} - 16'd1;
        px_ahead   = field_x + {6'd0, user_xe};
        px_behind  = field_x + {6'd0, user_xs} - 16'd1;
        col_ahead  = px_ahead >> chip_shift;
        top_lfoot  = ground_top(6'(px_lfoot >> chip_shift));
        top_rfoot  = ground_top(6'(px_rfoot >> chip_shift));
        top_ahead  = ground_top(6'(col_ahead));
        top_behind = ground_top(6'(px_behind >> chip_shift));
    end

    // smaller y is higher on screen
    always_comb begin
        fall_ok = (user_ye < top_lfoot) && (user_ye < top_rfoot)
               && (user_ye < 10'(v_disp));          // never sink below the screen
        blocked_right = (user_xe >= 10'(h_disp))    // screen edge
                     || (col_ahead >= map_width)    // end of map
                     || (top_ahead < user_ye);      // wall ahead
        blocked_left  = (user_xs == 10'd0 && field_x == 16'd0)
                     || (top_behind < user_ye);
    end

    // registered, one cycle behind the box
    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            map_free <= '0;
        end else begin
            map_free[free_up]    <= 1'b1;           // no ceilings
            map_free[free_down]  <= fall_ok;
            map_free[free_right] <= !blocked_right;
            map_free[free_left]  <= !blocked_left;
        end
    end

endmodule

// ==== source/player_motion.sv ====
// player motion engine, horizontal ramp and scroll, two-jump vertical arc
module player_motion (
    input  logic        iClk,
    input  logic        arst_n,
    input  logic [5:0]  btn,
    input  logic        tick_1ms,
    input  logic [9:0]  start_x,
    input  logic [9:0]  start_y,
    input  logic [3:0]  map_free,
    input  logic [15:0] map_width,
    output logic [9:0]  user_xs,
    output logic [9:0]  user_ys,
    output logic [9:0]  user_xe,
    output logic [9:0]  user_ye,
    output logic [15:0] field_x,
    output logic [15:0] field_y,
    output logic [1:0]  dir_x,
    output logic [1:0]  dir_y
);

    import game_pkg::*;

    logic [1:0]  last_dir;                  // single key held before both
    logic [3:0]  speed_cnt;                 // ticks to the next step
    logic [3:0]  speed_comp;                // reload, shrinks while held
    logic        x_held;
    logic        x_step;
    logic [15:0] scroll_limit;              // map columns needed to keep scrolling
    logic        a_prev;
    logic        a_rise;                    // fresh A press
    logic [1:0]  jump_cnt;                  // jumps used this airtime
    logic [5:0]  jump_height;               // speed index along the arc
    logic [3:0]  step_cnt;
    logic [3:0]  step_comp;

    assign user_xe = user_xs + 10'(user_width);
    assign user_ye = user_ys + 10'(user_height);

    assign x_held       = btn[btn_right] | btn[btn_left];
    assign x_step       = tick_1ms && (speed_cnt == 4'(key_end_time));
    assign scroll_limit = 16'(h_chip_number) + (field_x >> 5);

    // ------------------------------------------------------------------------
    // facing, the newer key wins when both are held
    // ------------------------------------------------------------------------
    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            dir_x    <= xdir_idle;
            last_dir <= xdir_idle;
        end else begin
            case ({btn[btn_right], btn[btn_left]})
                2'b01: begin
                    dir_x    <= xdir_left;
                    last_dir <= xdir_left;
                end
                2'b10: begin
                    dir_x    <= xdir_right;
                    last_dir <= xdir_right;
                end
                2'b11: dir_x <= (last_dir == xdir_right) ? xdir_left : xdir_right;
                default: begin
                    dir_x    <= xdir_idle;
                    last_dir <= xdir_idle;
                end
            endcase
        end
    end

    // long press ramp, gap 14 ticks down to 3
    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            speed_cnt  <= 4'(key_start_time);
            speed_comp <= 4'(key_start_time);
        end else if (!x_held) begin
            speed_cnt  <= 4'(key_start_time);   // restart slow
            speed_comp <= 4'(key_start_time);
        end else if (x_step) begin
            speed_cnt <= speed_comp;
            if (speed_comp != 4'(key_comp_time)) begin
                speed_comp <= speed_comp - 1'b1;
            end
        end else if (tick_1ms) begin
            speed_cnt <= speed_cnt - 1'b1;
        end
    end

    // move on screen, or scroll the field past mid-screen
    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            user_xs <= start_x;
            field_x <= '0;
        end else if (x_step) begin
            case (dir_x)
                xdir_right: if (map_free[free_right]) begin
                    if (user_xs < 10'(h_disp_half) || map_width < scroll_limit) begin
                        user_xs <= user_xs + 1'b1;
                    end else begin
                        field_x <= field_x + 1'b1;
                    end
                end
                xdir_left: if (map_free[free_left]) begin
                    if (field_x == '0 || user_xs > 10'(h_disp_half)) begin
                        if (user_xs != '0) begin
                            user_xs <= user_xs - 1'b1;  // no wrap at the edge
                        end
                    end else begin
                        field_x <= field_x - 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // no vertical scroll yet
    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) field_y <= '0;
        else         field_y <= '0;
    end

    // ------------------------------------------------------------------------
    // jump arc, ticks per pixel from the speed index
    // ------------------------------------------------------------------------
    function automatic logic [3:0] step_period(input logic [5:0] h);
        logic [3:0] p;
        if      (h >= 6'd30) p = 4'd3;      // fast near the ground
        else if (h >= 6'd19) p = 4'd5;
        else if (h >= 6'd8)  p = 4'd7;
        else if (h >= 6'd4)  p = 4'd10;
        else                 p = 4'd12;     // hang at the apex
        return p;
    endfunction

    assign step_comp = step_period(jump_height);
    assign a_rise    = btn[btn_a] & ~a_prev;

    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) a_prev <= 1'b0;
        else         a_prev <= btn[btn_a];
    end

    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            user_ys     <= start_y;
            dir_y       <= ydir_idle;
            jump_cnt    <= '0;
            jump_height <= '0;
            step_cnt    <= '0;
        end else begin
            case (dir_y)
                ydir_idle: begin
                    step_cnt <= '0;
                    if (a_rise) begin
                        dir_y       <= ydir_jump;
                        jump_cnt    <= 2'd1;
                        jump_height <= 6'(jump_height_max);
                    end else if (map_free[free_down]) begin
                        dir_y       <= ydir_fall;       // ground dropped away
                        jump_cnt    <= 2'd1;
                        jump_height <= 6'(fall_start_height);
                    end
                end
                ydir_jump: begin
                    if (!btn[btn_a] || jump_height == '0 || !map_free[free_up]
                        || user_ys == '0) begin
                        dir_y    <= ydir_fall;          // released or apex
                        step_cnt <= '0;
                    end else if (tick_1ms) begin
                        if (step_cnt == step_comp) begin
                            user_ys     <= user_ys - 1'b1;
                            jump_height <= jump_height - 1'b1;
                            step_cnt    <= '0;
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                        end
                    end
                end
                ydir_fall: begin
                    if (a_rise && jump_cnt < 2'(jump_max_count)) begin
                        dir_y       <= ydir_jump;       // second jump
                        jump_cnt    <= jump_cnt + 1'b1;
                        jump_height <= 6'(jump_height_max);
                        step_cnt    <= '0;
                    end else if (!map_free[free_down]) begin
                        dir_y    <= ydir_idle;          // landed
                        jump_cnt <= '0;
                        step_cnt <= '0;
                    end else if (tick_1ms) begin
                        if (step_cnt == step_comp) begin
                            user_ys  <= user_ys + 1'b1;
                            step_cnt <= '0;
                            if (jump_height != 6'(jump_height_max)) begin
                                jump_height <= jump_height + 1'b1;  // speeds up
                            end
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                        end
                    end
                end
                default: dir_y <= ydir_idle;
            endcase
        end
    end

endmodule

// ==== source/player_top.sv ====
// top level, tick generator, button debouncer, terrain probe and motion engine
module player_top #(
    parameter int tick_div = 100000         // 1 ms at 100 MHz
) (
    input  logic        iClk,
    input  logic        arst_n,
    input  logic [5:0]  btn_raw,
    input  logic [9:0]  start_x,
    input  logic [9:0]  start_y,
    input  logic [15:0] map_width,
    output logic [9:0]  user_xs,
    output logic [9:0]  user_ys,
    output logic [9:0]  user_xe,
    output logic [9:0]  user_ye,
    output logic [15:0] field_x,
    output logic [15:0] field_y,
    output logic [1:0]  dir_x,
    output logic [1:0]  dir_y
);

    logic       tick_1ms;                   // game time base
    logic [5:0] btn;                        // debounced keys
    logic [3:0] map_free;

    tick_gen #(
        .tick_div (tick_div)
    ) u_tick_gen (
        .iClk     (iClk),
        .arst_n   (arst_n),
        .tick_1ms (tick_1ms)
    );

    button_sync u_button_sync (
        .iClk     (iClk),
        .arst_n   (arst_n),
        .tick_1ms (tick_1ms),
        .btn_raw  (btn_raw),
        .btn      (btn)
    );

    // probe looks at last cycle's box
    terrain_probe u_terrain_probe (
        .iClk      (iClk),
        .arst_n    (arst_n),
        .user_xs   (user_xs),
        .user_xe   (user_xe),
        .user_ye   (user_ye),
        .field_x   (field_x),
        .map_width (map_width),
        .map_free  (map_free)
    );

    player_motion u_player_motion (
        .iClk      (iClk),
        .arst_n    (arst_n),
        .btn       (btn),
        .tick_1ms  (tick_1ms),
        .start_x   (start_x),
        .start_y   (start_y),
        .map_free  (map_free),
        .map_width (map_width),
        .user_xs   (user_xs),
        .user_ys   (user_ys),
        .user_xe   (user_xe),
        .user_ye   (user_ye),
        .field_x   (field_x),
        .field_y   (field_y),
        .dir_x     (dir_x),
        .dir_y     (dir_y)
    );

endmodule

// ==== test/tb_player_top.sv ====
// player_top testbench with clock, reset, button stimulus, assertions and watchdog
module tb_player_top;

    timeunit 1ns;
    timeprecision 100ps;

    import game_pkg::*;

    localparam int tick_div     = 4;        // short game tick for simulation
    localparam int clk_per      = 8;
    localparam int ground_ys    = 384;      // box top standing on the plain floor
    localparam int settle_ticks = 1500;     // debounce, falls and landings outside the holds

    logic        iClk;
    logic        arst_n;
    logic [5:0]  btn_raw;
    logic [9:0]  start_x;
    logic [9:0]  start_y;
    logic [15:0] map_width;
    logic [9:0]  user_xs;
    logic [9:0]  user_ys;
    logic [9:0]  user_xe;
    logic [9:0]  user_ye;
    logic [15:0] field_x;
    logic [15:0] field_y;
    logic [1:0]  dir_x;
    logic [1:0]  dir_y;

    integer      seed = 74061;
    int          hold_len [8];              // press lengths in ticks
    int          budget_ticks;
    logic        budget_ready = 1'b0;
    logic [16:0] pos_sum;                   // world x of the box
    logic [16:0] last_sum;
    logic [1:0]  last_dir_x;
    logic [1:0]  last_dir_y;
    bit          mon_valid;
    int          air_jumps;                 // jumps started since leaving the ground
    logic [9:0]  jump_base;                 // box top when the current jump began

    player_top #(
        .tick_div  (tick_div)
    ) u_dut (
        .iClk      (iClk),
        .arst_n    (arst_n),
        .btn_raw   (btn_raw),
        .start_x   (start_x),
        .start_y   (start_y),
        .map_width (map_width),
        .user_xs   (user_xs),
        .user_ys   (user_ys),
        .user_xe   (user_xe),
        .user_ye   (user_ye),
        .field_x   (field_x),
        .field_y   (field_y),
        .dir_x     (dir_x),
        .dir_y     (dir_y)
    );

    initial iClk = 1'b0;
    always #(clk_per / 2) iClk = ~iClk;

    assign pos_sum = {7'd0, user_xs} + {1'b0, field_x};

    // ------------------------------------------------------------------------
    // failure reporting and small helpers
    // ------------------------------------------------------------------------
    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic fail_value(input string sig, input longint got, input longint exp);
        fail_now($sformatf("Fail %s got 0x%0h expected 0x%0h", sig, got, exp));
    endtask

    task automatic check_eq(input string sig, input longint got, input longint exp);
        assert (got == exp) else fail_value(sig, got, exp);
    endtask

    function automatic int draw_hold(input int base, input int span);
        return base + int'($unsigned($random(seed)) % span);
    endfunction

    task automatic drive_buttons(input logic [5:0] b);
        @(posedge iClk);
        btn_raw <= b;
    endtask

    task automatic wait_ticks(input int n);
        repeat (n * tick_div) @(posedge iClk);
    endtask

    task automatic wait_dir_x(input logic [1:0] code);
        do @(negedge iClk); while (dir_x !== code);
    endtask

    task automatic wait_dir_y(input logic [1:0] code);
        do @(negedge iClk); while (dir_y !== code);
    endtask

    // drop A mid-rise, the box must start falling within a tick
    task automatic release_jump_key();
        drive_buttons('0);
        do @(negedge iClk); while (u_dut.btn[btn_a] !== 1'b0);     // debounced release
        wait_ticks(1);
        @(negedge iClk);
        check_eq("dir_y", dir_y, ydir_fall);
    endtask

    // called on a rising edge or at time 0
    task automatic apply_reset(input logic [9:0] x, input logic [9:0] y);
        arst_n  <= 1'b0;
        btn_raw <= '0;
        start_x <= x;
        start_y <= y;
        repeat (2) @(posedge iClk);
        arst_n <= 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // concurrent checks
    // ------------------------------------------------------------------------
    box_width: assert property (@(posedge iClk) disable iff (!arst_n)
        user_xe == user_xs + 10'(user_width))
        else fail_value("user_xe", $sampled(user_xe), $sampled(user_xs) + user_width);

    box_height: assert property (@(posedge iClk) disable iff (!arst_n)
        user_ye == user_ys + 10'(user_height))
        else fail_value("user_ye", $sampled(user_ye), $sampled(user_ys) + user_height);

    // at mid-screen a right step scrolls the field
    scroll_hold: assert property (@(posedge iClk) disable iff (!arst_n)
        ($past(dir_x) == xdir_right && $past(user_xs) == 10'(h_disp_half)
         && map_width > ($past(field_x) >> 5) + 16'(h_chip_number))
        |-> user_xs == 10'(h_disp_half))
        else fail_value("user_xs", $sampled(user_xs), h_disp_half);

    no_wrap: assert property (@(posedge iClk) disable iff (!arst_n)
        user_xs < 10'(h_disp))
        else fail_value("user_xs", $sampled(user_xs), 0);

    jump_rise: assert property (@(posedge iClk) disable iff (!arst_n)
        dir_y == ydir_jump |-> int'(jump_base) - int'(user_ys) <= jump_height_max)
        else fail_value("user_ys", $sampled(user_ys), $sampled(jump_base) - jump_height_max);

    below_ground: assert property (@(posedge iClk) disable iff (!arst_n)
        user_ys <= 10'(ground_ys))
        else fail_value("user_ys", $sampled(user_ys), ground_ys);

    always @(posedge iClk) begin
        if (dir_y != ydir_jump) jump_base <= user_ys;   // frozen while rising
    end

    // per-cycle step rules sampled between edges
    always @(negedge iClk) begin
        if (arst_n && mon_valid) begin
            if (last_dir_x == xdir_right) begin
                assert (pos_sum >= last_sum && pos_sum <= last_sum + 17'd1)
                    else fail_value("user_xs+field_x", pos_sum, last_sum + 1);
            end else if (last_dir_x == xdir_left) begin
                assert (pos_sum <= last_sum && pos_sum + 17'd1 >= last_sum)
                    else fail_value("user_xs+field_x", pos_sum, last_sum);
            end else begin
                assert (pos_sum == last_sum) else fail_value("user_xs+field_x", pos_sum, last_sum);
            end
        end
        if (!arst_n || dir_y == ydir_idle) begin
            air_jumps = 0;
        end else if (dir_y == ydir_jump && last_dir_y != ydir_jump) begin
            air_jumps = air_jumps + 1;
        end
        assert (air_jumps <= jump_max_count) else fail_value("air_jumps", air_jumps, jump_max_count);
        last_sum   = pos_sum;
        last_dir_x = dir_x;
        last_dir_y = dir_y;
        mon_valid  = arst_n;
    end

    // run length follows the drawn holds
    initial begin
        wait (budget_ready);
        #(budget_ticks * tick_div * clk_per);
        fail_now("Timeout, the motion sequence did not finish in time");
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        int         total;
        logic [16:0] sum_mark;

        arst_n    = 1'b0;
        btn_raw   = '0;
        start_x   = 10'd300;                // 20 steps short of the scroll point
        start_y   = 10'(ground_ys);
        map_width = 16'd200;                // wide enough to keep scrolling

        hold_len[0] = draw_hold(200, 64);   // right alone, reaches the scroll point
        hold_len[1] = draw_hold(20, 16);    // left added to right
        hold_len[2] = draw_hold(20, 16);    // left alone
        hold_len[3] = draw_hold(40, 16);    // right added to left
        hold_len[4] = draw_hold(340, 32);   // single jump held past the apex
        hold_len[5] = draw_hold(30, 16);    // first jump of the pair
        hold_len[6] = draw_hold(16, 8);     // jump again in the air
        hold_len[7] = draw_hold(110, 32);   // left into the screen edge
        total = 0;
        foreach (hold_len[i]) total += hold_len[i];
        budget_ticks = total + settle_ticks;
        budget_ready = 1'b1;

        apply_reset(10'd300, 10'(ground_ys));
        @(negedge iClk);
        check_eq("user_xs", user_xs, start_x);
        check_eq("user_ys", user_ys, start_y);
        check_eq("field_x", field_x, 0);
        check_eq("field_y", field_y, 0);
        check_eq("dir_x", dir_x, xdir_idle);
        check_eq("dir_y", dir_y, ydir_idle);

        // right until the field scrolls
        drive_buttons(6'b000001 << btn_right);
        wait_dir_x(xdir_right);
        wait_ticks(hold_len[0]);
        @(negedge iClk);
        check_eq("user_xs", user_xs, h_disp_half);
        assert (field_x != 0) else fail_now($sformatf("Fail field_x 0x%0h, no scroll", field_x));

        // newer key wins
        drive_buttons((6'b1 << btn_right) | (6'b1 << btn_left));
        wait_dir_x(xdir_left);
        sum_mark = pos_sum;
        wait_ticks(hold_len[1]);
        @(negedge iClk);
        assert (pos_sum < sum_mark)
            else fail_now($sformatf("Fail user_xs+field_x 0x%0h, not below 0x%0h", pos_sum, sum_mark));
        drive_buttons('0);
        wait_dir_x(xdir_idle);

        drive_buttons(6'b1 << btn_left);
        wait_dir_x(xdir_left);
        wait_ticks(hold_len[2]);
        drive_buttons((6'b1 << btn_right) | (6'b1 << btn_left));
        wait_dir_x(xdir_right);
        sum_mark = pos_sum;
        wait_ticks(hold_len[3]);
        @(negedge iClk);
        assert (pos_sum > sum_mark)
            else fail_now($sformatf("Fail user_xs+field_x 0x%0h, not above 0x%0h", pos_sum, sum_mark));
        drive_buttons('0);
        wait_dir_x(xdir_idle);

        // near the left edge for the jumps and the edge stop
        @(posedge iClk);
        apply_reset(10'd6, 10'(ground_ys));
        @(negedge iClk);
        check_eq("user_xs", user_xs, 6);

        // single jump and landing
        drive_buttons(6'b1 << btn_a);
        wait_dir_y(ydir_jump);
        wait_ticks(hold_len[4]);
        drive_buttons('0);
        wait_dir_y(ydir_fall);
        wait_dir_y(ydir_idle);
        check_eq("user_ys", user_ys, ground_ys);

        // second jump mid-fall and a refused third
        drive_buttons(6'b1 << btn_a);
        wait_dir_y(ydir_jump);
        wait_ticks(hold_len[5]);
        release_jump_key();
        drive_buttons(6'b1 << btn_a);
        wait_dir_y(ydir_jump);
        wait_ticks(hold_len[6]);
        release_jump_key();
        check_eq("air_jumps", air_jumps, jump_max_count);
        drive_buttons(6'b1 << btn_a);
        do @(negedge iClk); while (u_dut.btn[btn_a] !== 1'b1);     // debounced press
        wait_ticks(2);
        @(negedge iClk);
        check_eq("dir_y", dir_y, ydir_fall);
        check_eq("air_jumps", air_jumps, jump_max_count);
        drive_buttons('0);
        wait_dir_y(ydir_idle);
        check_eq("user_ys", user_ys, ground_ys);

        // left into the screen edge
        drive_buttons(6'b1 << btn_left);
        wait_ticks(hold_len[7]);
        @(negedge iClk);
        check_eq("user_xs", user_xs, 0);
        check_eq("field_x", field_x, 0);
        drive_buttons('0);

        @(negedge iClk);
        $display("No errors");
        $finish;
    end

endmodule

// ==== sources.f ====
source/game_pkg.sv
source/tick_gen.sv
source/button_sync.sv
source/terrain_probe.sv
source/player_motion.sv
source/player_top.sv
test/tb_player_top.sv

// ==== Bender.yml ====
package:
  name: player_motion

sources:
  - files:
      - source/game_pkg.sv
      - source/tick_gen.sv
      - source/button_sync.sv
      - source/terrain_probe.sv
      - source/player_motion.sv
      - source/player_top.sv
  - target: test
    files:
      - test/tb_player_top.sv
